//--- verilog.f
+incdir+common
common/router_pkg.sv
rtl/route_decode.sv
fifo_arb/arb_fifo.sv
fifo_arb/fifo_arb.sv
rtl/router.sv
testbench/router_tb_clk.sv
testbench/router_asserts.sv
testbench/router_tb.sv

//--- Makefile
# Verilator build and run for the mesh router testbench

VERILATOR  ?= verilator
TOP        ?= router_tb
RTL_TOP    ?= router
FILELIST   ?= verilog.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation completed successfully" $(LOG) || \
		(echo "router simulation FAILED"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/router_tb.sv
`default_nettype none
`timescale 1ns/1ns

`include "router_defines.svh"

module router_tb
import router_pkg::*;
;
    localparam int TILE_ROW = 5;
    localparam int TILE_COL = 6;

    logic                          clk;
    logic                          arst_n;
    t_tile_id                      local_tile_id;
    logic        [`NUM_PORTS-1:0]  valid_tile_trans_in;
    t_tile_trans [`NUM_PORTS-1:0]  tile_trans_in;
    logic        [`NUM_PORTS-1:0]  ready_tile_trans_out;
    logic        [`NUM_PORTS-1:0]  valid_tile_trans_out;
    t_tile_trans [`NUM_PORTS-1:0]  tile_trans_out;
    logic        [`NUM_PORTS-1:0]  ready_tile_trans_in;

    // scoreboard, expected tags per [input][output]
    int          exp_q [`NUM_PORTS][`NUM_PORTS][$];
    int          src_of [int];
    int          out_of [int];
    t_tile_trans sent_of [int];                     // whole transaction per tag
    int          wait_cnt [`NUM_PORTS][`NUM_PORTS];  // other grants since own, [out][in]
    int          accept_cnt [`NUM_PORTS];
    int          outstanding = 0;
    int          next_tag = 1;
    int          err_cnt = 0;
    // stimulus control, changed on falling edges only
    logic [`NUM_PORTS-1:0] send_en = '0;
    logic [`NUM_PORTS-1:0] hold_out = '0;          // force ready low
    logic [`NUM_PORTS-1:0] free_out = '0;          // force ready high
    int          fixed_dest [`NUM_PORTS] = '{-1, -1, -1, -1, -1};
    int          base_cnt;

    router_tb_clk router_tb_clk_inst (.clk(clk), .arst_n(arst_n));

    router router_inst (.*);

    bind router router_asserts router_asserts_inst (
        .clk(clk), .arst_n(arst_n), .valid_tile_trans_out(valid_tile_trans_out),
        .tile_trans_out(tile_trans_out), .ready_tile_trans_in(ready_tile_trans_in)
    );

    task automatic report_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        err_cnt++;
    endtask

    task automatic timeout_abort(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Simulation failed");
        $finish;
    endtask

    // dimension ordered rule on the flat word, row bits on top
    function automatic int route_ref(input logic [15:0] word);
        int row;
        int col;
        row = int'(word[15:12]);
        col = int'(word[11:8]);
        if (row > TILE_ROW) return `PORT_NORTH;
        if (row < TILE_ROW) return `PORT_SOUTH;
        if (col > TILE_COL) return `PORT_EAST;
        if (col < TILE_COL) return `PORT_WEST;
        return `PORT_LOCAL;
    endfunction

    // some address that should leave on port dest
    function automatic t_trans_addr make_addr(input int dest);
        t_trans_addr a;
        a.fields.row    = 4'(TILE_ROW);
        a.fields.col    = 4'(TILE_COL);
        a.fields.offset = 8'($urandom);
        case (dest)
            `PORT_NORTH: a.fields.row = 4'(TILE_ROW + 1 + $urandom % (15 - TILE_ROW));
            `PORT_SOUTH: a.fields.row = 4'($urandom % TILE_ROW);
            `PORT_EAST:  a.fields.col = 4'(TILE_COL + 1 + $urandom % (15 - TILE_COL));
            `PORT_WEST:  a.fields.col = 4'($urandom % TILE_COL);
            default:     ;
        endcase
        if (dest == `PORT_NORTH || dest == `PORT_SOUTH)
            a.fields.col = 4'($urandom);    // column is don't care off-row
        return a;
    endfunction

    function automatic int pick_dest(input int in_port);
        int d;
        d = $urandom % `NUM_PORTS;
        while (d == in_port) d = $urandom % `NUM_PORTS;   // never back out the same port
        return d;
    endfunction

    // ==================================================
    // output checks, then input drive, every rising edge
    // ==================================================
    always @(posedge clk) begin : drive_and_check
        logic [`NUM_PORTS-1:0] v_nxt;
        t_tile_trans [`NUM_PORTS-1:0] t_nxt;
        int tag;
        int s;
        int dest;
        if (arst_n) begin
            for (int o = 0; o < `NUM_PORTS; o++) begin
                if (valid_tile_trans_out[o] && ready_tile_trans_in[o]) begin
                    tag = int'(tile_trans_out[o].data);
                    if (!src_of.exists(tag)) begin
                        report_error($sformatf("unknown tag %0d on output %0d", tag, o));
                    end else begin
                        s = src_of[tag];
                        a_route: assert (out_of[tag] == o)
                        else report_error($sformatf("tag %0d on output %0d, expected %0d",
                                                    tag, o, out_of[tag]));
                        a_payload: assert (tile_trans_out[o] == sent_of[tag])
                        else report_error($sformatf("tag %0d on output %0d changed in flight",
                                                    tag, o));
                        a_order: assert (exp_q[s][o].size() > 0 && exp_q[s][o][0] == tag)
                        else report_error($sformatf("tag %0d out of order on %0d->%0d",
                                                    tag, s, o));
                        if (exp_q[s][o].size() > 0) begin
                            void'(exp_q[s][o].pop_front());
                            outstanding--;
                        end
                        for (int j = 0; j < `NUM_PORTS; j++) begin
                            if (j != s && exp_q[j][o].size() > 0) begin
                                wait_cnt[o][j]++;
                                a_fair: assert (wait_cnt[o][j] <= 3)
                                else report_error($sformatf("input %0d starved on output %0d",
                                                            j, o));
                            end else begin
                                wait_cnt[o][j] = 0;
                            end
                        end
                    end
                end
            end
            v_nxt = valid_tile_trans_in;
            t_nxt = tile_trans_in;
            for (int i = 0; i < `NUM_PORTS; i++) begin
                if (v_nxt[i] && ready_tile_trans_out[i]) begin   // accepted this edge
                    tag = int'(t_nxt[i].data);
                    src_of[tag] = i;
                    out_of[tag] = route_ref(t_nxt[i].address.word);
                    sent_of[tag] = t_nxt[i];
                    exp_q[i][out_of[tag]].push_back(tag);
                    accept_cnt[i]++;
                    outstanding++;
                    v_nxt[i] = 1'b0;
                end
                if (!v_nxt[i] && send_en[i] && ($urandom % 2 == 0)) begin
                    dest = (fixed_dest[i] >= 0) ? fixed_dest[i] : pick_dest(i);
                    t_nxt[i].opcode       = 2'($urandom);
                    t_nxt[i].requestor_id = 4'(i);
                    t_nxt[i].address      = make_addr(dest);
                    t_nxt[i].data         = 32'(next_tag);   // unique tag
                    next_tag++;
                    v_nxt[i] = 1'b1;
                end
            end
            valid_tile_trans_in <= v_nxt;
            tile_trans_in       <= t_nxt;
            for (int o = 0; o < `NUM_PORTS; o++)
                ready_tile_trans_in[o] <= !hold_out[o] && (free_out[o] || ($urandom % 4 != 0));
        end
    end

    task automatic drain();
        int t;
        send_en = '0;
        hold_out = '0;
        t = 0;
        while (outstanding != 0 || valid_tile_trans_in != '0) begin
            @(negedge clk);
            t++;
            if (t > 5000) timeout_abort("the router to drain");
        end
        for (int i = 0; i < `NUM_PORTS; i++) fixed_dest[i] = -1;
        free_out = '0;
    endtask

    // ==================================================
    // test sequence
    // ==================================================
    initial begin : main
        int t;
        void'($urandom(32'ha871));
        local_tile_id        = '{row: 4'(TILE_ROW), col: 4'(TILE_COL)};
        valid_tile_trans_in  = '0;
        tile_trans_in        = '0;
        ready_tile_trans_in  = '0;
        for (int i = 0; i < `NUM_PORTS; i++) accept_cnt[i] = 0;
        for (int o = 0; o < `NUM_PORTS; o++)
            for (int i = 0; i < `NUM_PORTS; i++) wait_cnt[o][i] = 0;
        t = 0;
        while (!arst_n) begin
            @(negedge clk);
            t++;
            if (t > 20) timeout_abort("reset release");
        end
        // random traffic on all ports
        @(negedge clk);
        send_en = '1;
        repeat (1500) @(negedge clk);
        drain();
        // one input fills a blocked output
        hold_out[`PORT_NORTH] = 1'b1;
        fixed_dest[`PORT_WEST] = `PORT_NORTH;
        base_cnt = accept_cnt[`PORT_WEST];
        send_en[`PORT_WEST] = 1'b1;
        t = 0;
        while (!(valid_tile_trans_in[`PORT_WEST] && !ready_tile_trans_out[`PORT_WEST])) begin
            @(negedge clk);
            t++;
            if (t > 200) timeout_abort("the west input to stall");
        end
        a_full: assert (accept_cnt[`PORT_WEST] - base_cnt == `FIFO_DEPTH + 1)
        else report_error($sformatf("%0d accepted before stall, expected %0d",
                                    accept_cnt[`PORT_WEST] - base_cnt, `FIFO_DEPTH + 1));
        drain();
        // four inputs compete for the local port
        hold_out[`PORT_LOCAL] = 1'b1;
        for (int i = 0; i < 4; i++) fixed_dest[i] = `PORT_LOCAL;
        send_en = 5'b01111;
        t = 0;
        while ((valid_tile_trans_in[3:0] & ~ready_tile_trans_out[3:0]) != 4'hf) begin
            @(negedge clk);
            t++;
            if (t > 500) timeout_abort("all inputs to stall on the local port");
        end
        hold_out[`PORT_LOCAL] = 1'b0;
        free_out[`PORT_LOCAL] = 1'b1;
        repeat (200) @(negedge clk);
        drain();
        $display("errors: testbench %0d, bound assertions %0d",
                 err_cnt, router_inst.router_asserts_inst.fail_cnt);
        if (err_cnt == 0 && router_inst.router_asserts_inst.fail_cnt == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/router_asserts.sv
`default_nettype none
`timescale 1ns/1ns

`include "router_defines.svh"

module router_asserts
import router_pkg::*;
(
    input logic                         clk,
    input logic                         arst_n,
    input logic        [`NUM_PORTS-1:0] valid_tile_trans_out,
    input t_tile_trans [`NUM_PORTS-1:0] tile_trans_out,
    input logic        [`NUM_PORTS-1:0] ready_tile_trans_in
);

    int unsigned rst_fails = 0;
    int unsigned fail_cnt;              // read by the testbench top

    // ==================================================
    // back-pressure, one checker per output
    // ==================================================
    for (genvar o = 0; o < `NUM_PORTS; o++) begin : g_port
        int unsigned cnt = 0;
        a_hold: assert property (@(posedge clk) disable iff (!arst_n)
            valid_tile_trans_out[o] && !ready_tile_trans_in[o]
            |=> valid_tile_trans_out[o] && $stable(tile_trans_out[o]))
        else begin
            $error("output %0d lost or changed its transaction while stalled", o);
            cnt++;
        end
    end

    // outputs quiet in reset and on the first edge out of it
    a_rst_low: assert property (@(posedge clk) !arst_n |-> valid_tile_trans_out == '0)
    else begin
        $error("output valid high during reset");
        rst_fails++;
    end

    a_rst_rel: assert property (@(posedge clk) $rose(arst_n) |-> valid_tile_trans_out == '0)
    else begin
        $error("output valid high on first edge after reset");
        rst_fails++;
    end

    assign fail_cnt = rst_fails + g_port[0].cnt + g_port[1].cnt + g_port[2].cnt
                    + g_port[3].cnt + g_port[4].cnt;

endmodule

`default_nettype wire

//--- testbench/router_tb_clk.sv
`default_nettype none
`timescale 1ns/1ns

module router_tb_clk (
    output logic clk,
    output logic arst_n
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reset held for two rising edges, released on the edge after
    initial begin
        arst_n = 1'b0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

`default_nettype wire

//--- rtl/router.sv
`default_nettype none
`timescale 1ns/1ns

`include "router_defines.svh"

module router
import router_pkg::*;
(
    input  logic                              clk,
    input  logic                              arst_n,
    input  t_tile_id                          local_tile_id,    // static
    // incoming side of each port
    input  logic        [`NUM_PORTS-1:0]      valid_tile_trans_in,
    input  t_tile_trans [`NUM_PORTS-1:0]      tile_trans_in,
    output logic        [`NUM_PORTS-1:0]      ready_tile_trans_out,
    // outgoing side of each port
    output logic        [`NUM_PORTS-1:0]      valid_tile_trans_out,
    output t_tile_trans [`NUM_PORTS-1:0]      tile_trans_out,
    input  logic        [`NUM_PORTS-1:0]      ready_tile_trans_in
);

    // decoder side, indexed [input][lane]
    logic [3:0]        dec_valid [`NUM_PORTS];
    logic [3:0]        dec_ready [`NUM_PORTS];

    // arbiter side, indexed [output][slot]
    logic [3:0]        arb_valid [`NUM_PORTS];
    t_tile_trans [3:0] arb_trans [`NUM_PORTS];
    logic [3:0]        arb_ready [`NUM_PORTS];

    // ==================================================
    // decode stage, one per input
    // ==================================================
    for (genvar i = 0; i < `NUM_PORTS; i++) begin : g_dec
        route_decode #(
            .IN_PORT        (i)
        ) u_route_decode (
            .local_tile_id  (local_tile_id),
            .valid_in       (valid_tile_trans_in[i]),
            .trans_in       (tile_trans_in[i]),
            .ready_out      (ready_tile_trans_out[i]),
            .valid_to_arb   (dec_valid[i]),
            .ready_from_arb (dec_ready[i])
        );
    end

    // ==================================================
    // execute stage, one arbiter per output
    // ==================================================
    for (genvar o = 0; o < `NUM_PORTS; o++) begin : g_arb
        fifo_arb u_fifo_arb (
            .clk              (clk),
            .arst_n           (arst_n),
            .valid_alloc_req  (arb_valid[o]),
            .alloc_req        (arb_trans[o]),
            .ready_alloc      (arb_ready[o]),
            .valid_winner_req (valid_tile_trans_out[o]),   // straight to the port
            .winner_req       (tile_trans_out[o]),
            .ready_winner     (ready_tile_trans_in[o])
        );
    end

    // ==================================================
    // lane to slot crossbar
    // ==================================================
    // both sides skip their own index, so the numbering shifts by one past it
    for (genvar i = 0; i < `NUM_PORTS; i++) begin : g_in
        for (genvar o = 0; o < `NUM_PORTS; o++) begin : g_out
            if (i != o) begin : g_link
                localparam int LANE = (o < i) ? o : o - 1;  // lane of output o in decoder i
                localparam int SLOT = (i < o) ? i : i - 1;  // slot of input i in arbiter o

                assign arb_valid[o][SLOT] = dec_valid[i][LANE];
                assign arb_trans[o][SLOT] = tile_trans_in[i];   // payload fans out
                assign dec_ready[i][LANE] = arb_ready[o][SLOT];
            end
        end
    end

endmodule

`default_nettype wire

//--- fifo_arb/fifo_arb.sv
`default_nettype none
`timescale 1ns/1ns

`include "router_defines.svh"

module fifo_arb
import router_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    // one slot per input that may reach this output
    input  logic [3:0]        valid_alloc_req,
    input  t_tile_trans [3:0] alloc_req,
    output logic [3:0]        ready_alloc,
    // output slot
    output logic              valid_winner_req,
    output t_tile_trans       winner_req,
    input  logic              ready_winner
);

    logic [3:0]        q_valid;             // head valid per queue
    t_tile_trans [3:0] q_trans;             // head entry per queue
    logic [3:0]        q_pop;

    logic [1:0]        last_grant;          // rr pointer, moves on transfer
    logic [1:0]        base;                // search starts after this one
    logic [1:0]        pick;
    logic              pick_valid;
    logic              load;                // pick goes into output register
    logic              xfer;                // output handshake

    logic              out_valid;
    logic [1:0]        out_src;             // queue that supplied out_trans
    t_tile_trans       out_trans;

    // ==================================================
    // input queues
    // ==================================================
    for (genvar q = 0; q < 4; q++) begin : g_queue
        arb_fifo #(
            .DEPTH    (`FIFO_DEPTH)
        ) u_arb_fifo (
            .clk      (clk),
            .arst_n   (arst_n),
            .wr_valid (valid_alloc_req[q]),
            .wr_trans (alloc_req[q]),
            .wr_ready (ready_alloc[q]),
            .rd_valid (q_valid[q]),
            .rd_trans (q_trans[q]),
            .rd_pop   (q_pop[q])
        );
    end

    // ==================================================
    // round-robin pick
    // ==================================================
    // a held transaction already counts as the latest winner
    assign base = out_valid ? out_src : last_grant;

    always_comb begin
        pick       = base;
        pick_valid = 1'b0;
        for (int k = 1; k <= 4; k++) begin     // k=4 wraps back to base, lowest prio
            if (!pick_valid && q_valid[base + 2'(k)]) begin
                pick       = base + 2'(k);
                pick_valid = 1'b1;
            end
        end
    end

    assign xfer = out_valid & ready_winner;
    assign load = pick_valid & (~out_valid | ready_winner);   // register free or emptying

    always_comb begin
        for (int q = 0; q < 4; q++) begin
            q_pop[q] = load & (pick == 2'(q));
        end
    end

    // ==================================================
    // output register
    // ==================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid  <= 1'b0;
            out_src    <= '0;
            last_grant <= 2'd3;                     // queue 0 first after reset
        end else begin
            if (xfer)
                last_grant <= out_src;
            if (load) begin
                out_valid <= 1'b1;
                out_src   <= pick;
            end else if (xfer) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load)
            out_trans <= q_trans[pick];             // held while ready_winner low
    end

    assign valid_winner_req = out_valid;
    assign winner_req       = out_trans;

endmodule

`default_nettype wire

//--- fifo_arb/arb_fifo.sv
`default_nettype none
`timescale 1ns/1ns

`include "router_defines.svh"

module arb_fifo
import router_pkg::*;
#(
    parameter int DEPTH = `FIFO_DEPTH
)(
    input  logic        clk,
    input  logic        arst_n,
    // write side, from one route_decode
    input  logic        wr_valid,
    input  t_tile_trans wr_trans,
    output logic        wr_ready,
    // read side, toward the arbiter
    output logic        rd_valid,
    output t_tile_trans rd_trans,
    input  logic        rd_pop
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    t_tile_trans      mem [DEPTH];          // payload storage
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;                // occupancy
    logic [CNT_W-1:0] count_nxt;
    logic             full;                 // registered flags
    logic             empty;
    logic             do_push;
    logic             do_pop;

    // a pop in the same cycle frees the slot for the incoming write
    assign wr_ready = ~full | rd_pop;
    assign rd_valid = ~empty;
    assign rd_trans = mem[rd_ptr];          // head of queue

    assign do_push = wr_valid & wr_ready;
    assign do_pop  = rd_pop & ~empty;

    always_comb begin
        case ({do_push, do_pop})
            2'b10:   count_nxt = count + 1'b1;
            2'b01:   count_nxt = count - 1'b1;
            default: count_nxt = count;     // idle or push+pop
        endcase
    end

    // ==================================================
    // pointers and count
    // ==================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            full   <= 1'b0;
            empty  <= 1'b1;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;   // wrap
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count_nxt;
            full  <= (count_nxt == CNT_W'(DEPTH));
            empty <= (count_nxt == '0);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= wr_trans;        // visible at head after this edge
    end

endmodule

`default_nettype wire

//--- rtl/route_decode.sv
`default_nettype none
`timescale 1ns/1ns

`include "router_defines.svh"

module route_decode
import router_pkg::*;
#(
    parameter int IN_PORT = `PORT_LOCAL   // input served by this instance
)(
    input  t_tile_id    local_tile_id,
    input  logic        valid_in,
    input  t_tile_trans trans_in,
    output logic        ready_out,
    output logic [3:0]  valid_to_arb,       // one lane per reachable output
    input  logic [3:0]  ready_from_arb
);

    logic [`NUM_PORTS-1:0] dest_onehot;     // indexed by port number
    logic [3:0]            lane_sel;        // dest_onehot folded onto lanes
    logic                  turn_back;       // dest is the arriving port

    // lane l feeds output port l, or l+1 once past our own port
    function automatic int lane_port(input int lane);
        return (lane < IN_PORT) ? lane : lane + 1;
    endfunction

    // ==================================================
    // dimension ordered decode, row first then column
    // ==================================================
    always_comb begin
        dest_onehot = '0;
        if (trans_in.address.fields.row > local_tile_id.row)
            dest_onehot[`PORT_NORTH] = 1'b1;                // row still above us
        else if (trans_in.address.fields.row < local_tile_id.row)
            dest_onehot[`PORT_SOUTH] = 1'b1;
        else if (trans_in.address.fields.col > local_tile_id.col)
            dest_onehot[`PORT_EAST] = 1'b1;                 // right row, move along it
        else if (trans_in.address.fields.col < local_tile_id.col)
            dest_onehot[`PORT_WEST] = 1'b1;
        else
            dest_onehot[`PORT_LOCAL] = 1'b1;                // both ids hit
    end

    // drop our own port from the set
    always_comb begin
        for (int l = 0; l < 4; l++) begin
            lane_sel[l] = dest_onehot[lane_port(l)];
        end
    end

    assign turn_back = dest_onehot[IN_PORT];

    assign valid_to_arb = lane_sel & {4{valid_in}};

    // no queue exists for a turn-back, it is sunk so the input never locks up
    assign ready_out = turn_back | (|(lane_sel & ready_from_arb));

endmodule

`default_nettype wire

//--- common/router_pkg.sv
`default_nettype none

`include "router_defines.svh"

package router_pkg;

    // ==================================================
    // address as seen by the router
    // ==================================================
    typedef struct packed {
        logic [`ROW_W-1:0]    row;      // msb side, decoded first
        logic [`COL_W-1:0]    col;
        logic [`OFFSET_W-1:0] offset;   // not looked at by routing
    } t_addr_fields;

    // same 16 bits, two views
    // router decodes the fields, the local agent takes the flat word
    typedef union packed {
        logic [`ADDR_W-1:0] word;
        t_addr_fields       fields;
    } t_trans_addr;

    // own position of this tile in the mesh
    typedef struct packed {
        logic [`ROW_W-1:0] row;
        logic [`COL_W-1:0] col;
    } t_tile_id;

    // ==================================================
    // one transaction, 54 bits
    // ==================================================
    typedef struct packed {
        logic [1:0]         opcode;         // carried only
        logic [3:0]         requestor_id;
        t_trans_addr        address;
        logic [`DATA_W-1:0] data;
    } t_tile_trans;

endpackage

`default_nettype wire

//--- common/router_defines.svh
`ifndef ROUTER_DEFINES_SVH
`define ROUTER_DEFINES_SVH

// ==================================================
// address and payload widths
// ==================================================
`define ROW_W       4                               // row id field
`define COL_W       4                               // column id field
`define OFFSET_W    8                               // offset inside the target tile
`define ADDR_W      (`ROW_W + `COL_W + `OFFSET_W)   // 16 bit flat address
`define DATA_W      32                              // payload word

// per-input queue inside each output arbiter
`define FIFO_DEPTH  4

// ==================================================
// port indices
// ==================================================
`define NUM_PORTS   5
`define PORT_EAST   0
`define PORT_WEST   1
`define PORT_NORTH  2
`define PORT_SOUTH  3
`define PORT_LOCAL  4   // the tile's own agent

`endif
